//--- common/noc_pkg.sv
`default_nettype none

package noc_pkg;

	////////////////////////////////////////////////////////////////////////////
	// flit and word geometry
	////////////////////////////////////////////////////////////////////////////

	localparam int PAYLOAD_BITS   = 10; // payload field of every flit
	localparam int FLIT_BITS      = PAYLOAD_BITS + 1; // payload plus tail
	localparam int WORD_BITS      = 32; // core word width
	localparam int FLITS_PER_WORD = 3; // data flits needed for one word
	localparam int ROUTED_BITS    = 30; // word bits that cross the network

	// header flit   [ route   | tail ]
	// data flit     [ payload | tail ]
	// core word     [ code(8) | data(24) ], top two code bits never routed

	typedef logic [PAYLOAD_BITS-1:0] payload_t;
	typedef logic [PAYLOAD_BITS-1:0] route_t; // rides in a header payload
	typedef logic [FLIT_BITS-1:0]    flit_t; // payload in [10:1], tail in [0]
	typedef logic [WORD_BITS-1:0]    core_word_t;

	////////////////////////////////////////////////////////////////////////////
	// flit field helpers
	////////////////////////////////////////////////////////////////////////////

	// build a flit from a payload and a tail bit
	function automatic flit_t make_flit(input payload_t payload, input logic tail);
		flit_t f;
		f = {payload, tail};
		return f;
	endfunction

	// upper ten bits of a flit
	function automatic payload_t flit_payload(input flit_t f);
		return f[FLIT_BITS-1:1];
	endfunction

	// tail marks the final flit of a packet
	function automatic logic flit_tail(input flit_t f);
		return f[0];
	endfunction

endpackage

`default_nettype wire

//--- logic/flit_fifo.sv
`default_nettype none

// show-ahead fifo, head is valid whenever empty is low
module flit_fifo import noc_pkg::*; #(
	parameter int DEPTH = 8 // power of two, 4 or more
) (
	input  logic  clk,
	input  logic  reset,
	input  flit_t write_data,
	input  logic  write_en,
	output logic  full,
	output flit_t head,
	output logic  empty,
	input  logic  pop
);

	localparam int ADDR_BITS = $clog2(DEPTH);

	flit_t                mem [DEPTH]; // storage, no reset needed
	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0]   count; // one extra bit so DEPTH fits

	logic do_write;
	logic do_read;

	assign do_write = write_en && !full; // writes while full are lost
	assign do_read  = pop && !empty;

	assign full  = (count == (ADDR_BITS+1)'(DEPTH));
	assign empty = (count == '0);
	assign head  = mem[rd_ptr]; // show-ahead

	// storage
	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= write_data;
		end
	end

	// pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_write) wr_ptr <= wr_ptr + 1'b1;
			if (do_read)  rd_ptr <= rd_ptr + 1'b1;
			case ({do_write, do_read})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

endmodule

`default_nettype wire

//--- deserializer/flit_deserializer.sv
`default_nettype none

// ingress side, gathers three data flits per word from the fifo head
module flit_deserializer import noc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  flit_t      head, // fifo head, show-ahead
	input  logic       empty,
	output logic       pop,
	output core_word_t core_out_word,
	output logic       core_out_valid,
	input  logic       core_out_ack
);

	typedef enum logic [2:0] {
		wait_header, // drop the zeroed header flit
		chunk0, // bits 29:20
		chunk1, // bits 19:10
		chunk2, // bits 9:0, tail sampled here
		present // word offered to the core
	} state_t;

	state_t state;
	state_t state_next;

	logic [ROUTED_BITS-1:0] word_q; // routed part of the word
	logic                   tail_q; // last word of the packet

	////////////////////////////////////////////////////////////////////////////
	// next state and fifo pop
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		pop        = 1'b0;
		case (state)
			wait_header: begin
				pop = !empty; // header carries nothing
				if (!empty) state_next = chunk0;
			end
			chunk0: begin
				pop = !empty;
				if (!empty) state_next = chunk1;
			end
			chunk1: begin
				pop = !empty;
				if (!empty) state_next = chunk2;
			end
			chunk2: begin
				pop = !empty;
				if (!empty) state_next = present;
			end
			present: begin
				// hold here, fifo soaks up the stall
				if (core_out_ack) state_next = tail_q ? wait_header : chunk0;
			end
			default: state_next = wait_header;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state  <= wait_header;
			tail_q <= 1'b0;
		end else begin
			state <= state_next;
			if (state == chunk2 && !empty) tail_q <= flit_tail(head);
		end
	end

	// upper chunk arrives first, so shift in from the bottom
	always_ff @(posedge clk) begin
		if (pop && state != wait_header) begin
			word_q <= {word_q[ROUTED_BITS-PAYLOAD_BITS-1:0], flit_payload(head)};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// core side
	////////////////////////////////////////////////////////////////////////////

	assign core_out_valid = (state == present);
	assign core_out_word  = {{(WORD_BITS-ROUTED_BITS){1'b0}}, word_q}; // code bits 31:30 zero

endmodule

`default_nettype wire

//--- serializer/flit_serializer.sv
`default_nettype none

// egress side, turns a header or a word into flits under valid/ready
module flit_serializer import noc_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  logic       load_header, // present one route flit
	input  logic       load_word, // present three data flits
	input  logic       last, // word closes the packet
	input  route_t     route,
	input  core_word_t word,
	output logic       busy,
	output flit_t      flit_out,
	output logic       flit_out_valid,
	input  logic       flit_out_ready
);

	localparam int CNT_BITS = $clog2(FLITS_PER_WORD + 1);

	logic [ROUTED_BITS-1:0] shift_q; // outgoing chunk sits in the top bits
	logic [CNT_BITS-1:0]    remaining; // flits still to send
	logic                   last_q; // tail goes on the final chunk
	logic                   accept;
	logic                   tail_now;

	assign accept = flit_out_valid && flit_out_ready;

	////////////////////////////////////////////////////////////////////////////
	// control, flit counter and tail flag
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			remaining <= '0;
			last_q    <= 1'b0;
		end else if (load_header) begin
			remaining <= CNT_BITS'(1); // header is a single flit
			last_q    <= 1'b0; // header never carries the tail
		end else if (load_word) begin
			remaining <= CNT_BITS'(FLITS_PER_WORD);
			last_q    <= last;
		end else if (accept) begin
			remaining <= remaining - 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// payload shift register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (load_header) begin
			shift_q <= {route, {(ROUTED_BITS-PAYLOAD_BITS){1'b0}}};
		end else if (load_word) begin
			shift_q <= word[ROUTED_BITS-1:0]; // drop the two unrouted bits
		end else if (accept) begin
			shift_q <= shift_q << PAYLOAD_BITS; // next chunk to the top
		end
	end

	// tail only on the third chunk of a last word
	assign tail_now = last_q && (remaining == CNT_BITS'(1));

	assign flit_out_valid = (remaining != '0);
	assign busy           = (remaining != '0); // drops the cycle after the final accept
	assign flit_out       = make_flit(shift_q[ROUTED_BITS-1 -: PAYLOAD_BITS], tail_now);

endmodule

`default_nettype wire

//--- logic/ni_control.sv
`default_nettype none

// egress packet framing, one header per packet, then word loads
module ni_control import noc_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic core_in_valid,
	input  logic core_in_last,
	output logic core_in_ack,
	input  logic busy, // serializer still has flits out
	output logic load_header,
	output logic load_word,
	output logic last
);

	typedef enum logic [1:0] {
		idle, // waiting for a word and an idle serializer
		header, // header flit in flight
		word // data flits in flight
	} state_t;

	state_t state;
	state_t state_next;

	logic packet_open; // header already sent for this packet
	logic start; // a word can be acted on now

	assign start = (state == idle) && core_in_valid && !busy;

	////////////////////////////////////////////////////////////////////////////
	// handshake and serializer loads
	////////////////////////////////////////////////////////////////////////////

	// first word of a packet only triggers the header, ack comes later
	assign load_header = start && !packet_open;
	assign core_in_ack = start && packet_open;
	assign load_word   = core_in_ack; // serializer captures the acked word
	assign last        = core_in_last; // sampled with load_word

	always_comb begin
		state_next = state;
		case (state)
			idle: begin
				if (load_header) state_next = header;
				else if (core_in_ack) state_next = word;
			end
			header: begin
				// back to idle once the header flit is accepted
				if (!busy) state_next = idle;
			end
			word: begin
				if (!busy) state_next = idle; // all three chunks gone
			end
			default: state_next = idle;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// state and packet tracking
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!reset) begin
			state       <= idle;
			packet_open <= 1'b0;
		end else begin
			state <= state_next;
			if (load_header) begin
				packet_open <= 1'b1;
			end else if (core_in_ack && core_in_last) begin
				packet_open <= 1'b0; // next word starts a new packet
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/network_interface.sv
`default_nettype none

// network interface between a core and one mesh router port
module network_interface import noc_pkg::*; #(
	parameter int FIFO_DEPTH = 8 // ingress flit buffer
) (
	input  logic       clk,
	input  logic       reset,
	// core to network
	input  logic       core_in_valid,
	input  core_word_t core_in_word,
	input  route_t     core_in_route,
	input  logic       core_in_last,
	output logic       core_in_ack,
	output flit_t      flit_out,
	output logic       flit_out_valid,
	input  logic       flit_out_ready,
	// network to core
	input  flit_t      flit_in,
	input  logic       flit_in_valid,
	output logic       flit_in_ready,
	output core_word_t core_out_word,
	output logic       core_out_valid,
	input  logic       core_out_ack
);

	logic  busy;
	logic  load_header;
	logic  load_word;
	logic  last;
	logic  fifo_full;
	logic  fifo_empty;
	logic  fifo_pop;
	flit_t fifo_head;

	assign flit_in_ready = !fifo_full;

	////////////////////////////////////////////////////////////////////////////
	// egress
	////////////////////////////////////////////////////////////////////////////

	ni_control i_ni_control (
		.clk, .reset,
		.core_in_valid, .core_in_last, .core_in_ack,
		.busy, .load_header, .load_word, .last
	);

	flit_serializer i_flit_serializer (
		.clk, .reset,
		.load_header, .load_word, .last,
		.route(core_in_route), .word(core_in_word), // straight from the core
		.busy, .flit_out, .flit_out_valid, .flit_out_ready
	);

	////////////////////////////////////////////////////////////////////////////
	// ingress
	////////////////////////////////////////////////////////////////////////////

	flit_fifo #(.DEPTH(FIFO_DEPTH)) i_flit_fifo (
		.clk, .reset,
		.write_data(flit_in), .write_en(flit_in_valid && flit_in_ready),
		.full(fifo_full), .head(fifo_head), .empty(fifo_empty), .pop(fifo_pop)
	);

	flit_deserializer i_flit_deserializer (
		.clk, .reset,
		.head(fifo_head), .empty(fifo_empty), .pop(fifo_pop),
		.core_out_word, .core_out_valid, .core_out_ack
	);

endmodule

`default_nettype wire

//--- test/ni_tests.svh
// directed tests and their helpers included inside the testbench module

task automatic log_error(input string msg);
	$display("[ERROR] %0t: %s", $time, msg);
	error_count++;
endtask

// loopback switches on a falling edge and the stall settings just after a rising one
task automatic configure(input logic loop, input int ready_pct, input int ack_pct,
	input logic hold);
	@(negedge clk);
	loopback = loop;
	@(posedge clk);
	ready_stall_pct   = ready_pct;
	ack_stall_pct     = ack_pct;
	hold_ack          = hold;
	test_start_errors = error_count;
endtask

task automatic add_budget(input int flits);
	cycle_limit += flits * STALL_ALLOWANCE + TEST_SLACK;
endtask

// reference model where chunks go msb first and the tail rides on the last one
task automatic expect_word(input core_word_t w, input route_t r, input logic first,
	input logic last);
	if (first) exp_flits.push_back({r, 1'b0}); // header with a clear tail
	exp_flits.push_back({w[29:20], 1'b0});
	exp_flits.push_back({w[19:10], 1'b0});
	exp_flits.push_back({w[9:0], last});
	// words only come back to the core when flit_out feeds flit_in
	if (loopback) exp_words.push_back({2'b00, w[29:0]}); // unrouted bits come back zero
endtask

function automatic core_word_t random_word();
	core_word_t w;
	w = $urandom();
	if (w[31:30] == 2'b00) w[31] = 1'b1; // keep the unrouted bits nonzero
	return w;
endfunction

// hold the word on the core port until the DUT acks it
task automatic send_word(input core_word_t w, input route_t r, input logic last);
	@(negedge clk);
	core_in_valid = 1'b1;
	core_in_word  = w;
	core_in_route = r;
	core_in_last  = last;
	do @(posedge clk); while (!core_in_ack);
	@(negedge clk);
	core_in_valid = 1'b0;
	if (!flit_out_valid) log_error("no data flit on flit_out in the cycle after core_in_ack");
endtask

task automatic send_packet(input int n_words);
	route_t     r;
	core_word_t w;
	r = route_t'($urandom());
	add_budget(1 + n_words * FLITS_PER_WORD);
	for (int i = 0; i < n_words; i++) begin
		w = random_word();
		expect_word(w, r, i == 0, i == n_words - 1);
		send_word(w, r, i == n_words - 1);
	end
endtask

task automatic inject_flit(input flit_t f);
	@(negedge clk);
	drv_flit     = f;
	drv_in_valid = 1'b1;
	do @(posedge clk); while (!flit_in_ready);
	flits_accepted++;
endtask

task automatic inject_word(input core_word_t w, input logic last);
	inject_flit({w[29:20], 1'b0});
	inject_flit({w[19:10], 1'b0});
	inject_flit({w[9:0], last});
	exp_words.push_back({2'b00, w[29:0]});
endtask

// zero header as the routers leave it followed by random words
task automatic inject_packet(input int n_words);
	inject_flit('0);
	for (int i = 0; i < n_words; i++) inject_word(random_word(), i == n_words - 1);
	@(negedge clk);
	drv_in_valid = 1'b0;
endtask

////////////////////////////////////////////////////////////////////////////
// result check with one line per test
////////////////////////////////////////////////////////////////////////////

task automatic finish_test(input string name);
	while (out_flits.size() < exp_flits.size() || rx_words.size() < exp_words.size())
		@(posedge clk);
	repeat (FLITS_PER_WORD + 2) @(posedge clk); // room for a stray extra flit or word
	if (out_flits.size() != exp_flits.size() || rx_words.size() != exp_words.size())
		log_error($sformatf("%0d flits and %0d words, expected %0d and %0d",
			out_flits.size(), rx_words.size(), exp_flits.size(), exp_words.size()));
	foreach (exp_flits[i]) begin
		if (i < out_flits.size() && out_flits[i] !== exp_flits[i])
			log_error($sformatf("flit %0d is %h, expected %h", i, out_flits[i], exp_flits[i]));
	end
	foreach (exp_words[i]) begin
		if (i < rx_words.size() && rx_words[i] !== exp_words[i])
			log_error($sformatf("word %0d is %h, expected %h", i, rx_words[i], exp_words[i]));
	end
	tests_run++;
	if (error_count == test_start_errors) begin
		$display("test %0d %s: ok", tests_run, name);
	end else begin
		tests_failed++;
		$display("test %0d %s: %0d errors", tests_run, name, error_count - test_start_errors);
	end
	out_flits.delete();
	exp_flits.delete();
	rx_words.delete();
	exp_words.delete();
endtask

////////////////////////////////////////////////////////////////////////////
// tests
////////////////////////////////////////////////////////////////////////////

task automatic test_single_word();
	configure(1'b0, 0, 0, 1'b0);
	add_budget(1 + FLITS_PER_WORD);
	expect_word(32'hc123_4567, 10'h2b5, 1'b1, 1'b1);
	send_word(32'hc123_4567, 10'h2b5, 1'b1);
	finish_test("single-word egress");
endtask

task automatic test_multi_word();
	configure(1'b0, 0, 0, 1'b0);
	send_packet(5); // one header with the tail only on the fifth word
	finish_test("multi-word packet");
endtask

task automatic test_ingress();
	configure(1'b0, 0, 0, 1'b0);
	add_budget(1 + 2 * FLITS_PER_WORD);
	inject_flit('0);
	inject_word(32'hc3a5_5a3c, 1'b0);
	inject_word(32'h7f00_0ff1, 1'b1);
	@(negedge clk);
	drv_in_valid = 1'b0;
	finish_test("ingress injection");
endtask

task automatic test_loopback();
	configure(1'b1, 0, 0, 1'b0);
	repeat (6) send_packet(1 + int'($urandom_range(3)));
	finish_test("loopback");
endtask

task automatic test_backpressure();
	configure(1'b1, 40, 50, 1'b0); // stalls on both the flit link and the core
	repeat (6) send_packet(1 + int'($urandom_range(3)));
	finish_test("back-pressure");
endtask

task automatic test_full_fifo();
	int n_words;
	n_words = FIFO_DEPTH / FLITS_PER_WORD + 3; // more than the fifo and deserializer hold
	configure(1'b0, 0, 0, 1'b1);
	add_budget(1 + n_words * FLITS_PER_WORD);
	flits_accepted = 0;
	fork
		inject_packet(n_words);
		begin
			do @(posedge clk); while (flit_in_ready);
			// header and first word sit in the deserializer while the rest fill the fifo
			if (flits_accepted - 1 - FLITS_PER_WORD != FIFO_DEPTH)
				log_error($sformatf("fifo full after %0d flits, expected %0d",
					flits_accepted, FIFO_DEPTH + 1 + FLITS_PER_WORD));
			hold_ack = 1'b0;
		end
	join
	finish_test("full fifo");
endtask

//--- test/tb_network_interface.sv
`default_nettype none

// testbench top, the flit loopback path and the monitors live here
module tb_network_interface import noc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int FIFO_DEPTH      = 8;
	localparam int CLK_HALF        = 20; // 40 ns period
	localparam int RESET_CYCLES    = 16;
	localparam int STALL_ALLOWANCE = 12; // cycles per flit with random stalls
	localparam int TEST_SLACK      = 40; // setup and drain of one test

	logic       clk;
	logic       reset;
	logic       core_in_valid, core_in_last, core_in_ack;
	core_word_t core_in_word, core_out_word;
	route_t     core_in_route;
	flit_t      flit_out, flit_in;
	logic       flit_out_valid, flit_out_ready, flit_in_valid, flit_in_ready;
	logic       core_out_valid, core_out_ack;

	// stimulus state shared with the test tasks
	logic  loopback = 1'b0; // flit_out fed straight back into flit_in
	flit_t drv_flit;
	logic  drv_in_valid;
	logic  ready_gate; // random stall on the flit link
	logic  hold_ack = 1'b0; // core refuses every ingress word
	int    ready_stall_pct = 0;
	int    ack_stall_pct = 0;

	flit_t      exp_flits[$], out_flits[$];
	core_word_t exp_words[$], rx_words[$];
	logic       pend_valid = 1'b0; // word offered and not yet taken
	core_word_t pend_word;

	int error_count = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int flits_accepted = 0; // injected flits taken by the fifo
	int cycles = 0;
	int cycle_limit = RESET_CYCLES + TEST_SLACK; // grows with each test's traffic

	`include "ni_tests.svh"

	assign flit_in        = loopback ? flit_out : drv_flit;
	assign flit_in_valid  = loopback ? (flit_out_valid && ready_gate) : drv_in_valid;
	assign flit_out_ready = loopback ? (flit_in_ready && ready_gate) : ready_gate;

	network_interface #(.FIFO_DEPTH(FIFO_DEPTH)) i_network_interface (.*);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	// random stalls, new values on every falling edge
	initial begin
		ready_gate   = 1'b1;
		core_out_ack = 1'b0;
		forever begin
			@(negedge clk);
			ready_gate   = (int'($urandom_range(99)) >= ready_stall_pct);
			core_out_ack = !hold_ack && (int'($urandom_range(99)) >= ack_stall_pct);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// monitors
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (flit_out_valid && flit_out_ready) out_flits.push_back(flit_out);
	end

	// a pending word must hold still until the core takes it
	always @(posedge clk) begin
		if (pend_valid && !(core_out_valid && core_out_word === pend_word))
			log_error("core_out_valid or core_out_word changed before the ack");
		if (core_out_valid && core_out_ack) rx_words.push_back(core_out_word);
		pend_valid = core_out_valid && !core_out_ack;
		pend_word  = core_out_word;
	end

	initial begin
		while (cycles <= cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", cycle_limit);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		void'($urandom(32'h1959_1882));
		reset         = 1'b0;
		core_in_valid = 1'b0;
		core_in_word  = '0;
		core_in_route = '0;
		core_in_last  = 1'b0;
		drv_flit      = '0;
		drv_in_valid  = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;

		test_single_word();
		test_multi_word();
		test_ingress();
		test_loopback();
		test_backpressure();
		test_full_fifo();

		$display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
			error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- network_interface.f
+incdir+test
common/noc_pkg.sv
logic/flit_fifo.sv
deserializer/flit_deserializer.sv
serializer/flit_serializer.sv
logic/ni_control.sv
logic/network_interface.sv
test/tb_network_interface.sv

//--- Makefile
# Verilator build and run of the network interface testbench

VERILATOR ?= verilator
TOP       ?= tb_network_interface
FILELIST  ?= network_interface.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= Done: no errors

SIM     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard common/*.sv logic/*.sv serializer/*.sv deserializer/*.sv) \
	$(wildcard test/*.sv test/*.svh)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
test: $(SIM)
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
